/* filelist.f */
+incdir+testbench
source/ddr_rx_pkg.sv
source/ddr_scl_sampler.sv
source/ddr_word_deserializer.sv
source/ddr_crc5.sv
source/ddr_frame_checker.sv
source/ddr_rx_fifo.sv
source/ddr_rx_apb_regs.sv
source/ddr_rx_top.sv
testbench/ddr_rx_tb.sv

/* testbench/ddr_rx_model.svh */
//*********************************************************************
// HDR-DDR receive model
// frame encoder, expected FIFO contents and STATUS, typed compares
//*********************************************************************

// expected receiver state
rx_entry_t              exp_q[$];
logic [FRAME_CNT_W-1:0] exp_frames;
logic                   exp_ovf;
logic                   exp_par;
logic                   exp_tok;
logic                   exp_crc;
logic                   exp_pre;
logic                   rx_on;
logic [CRC_W-1:0]       crc_acc;
bit                     frame_bits[$];

// odd bits into the upper parity bit, inverted even bits into the lower
function automatic logic [PAR_W-1:0] word_parity(input logic [DATA_W-1:0] d);
  return {^(d & 16'hAAAA), ~^(d & 16'h5555)};
endfunction

// x^5 + x^2 + 1, one bit MSB first
function automatic logic [CRC_W-1:0] crc5_next(input logic [CRC_W-1:0] c, input bit b);
  logic [CRC_W-1:0] n;
  n = {c[3:0], 1'b0};
  if (c[4] ^ b)
    n = n ^ 5'b00101;
  return n;
endfunction

task automatic reset_model();
  exp_q.delete();
  frame_bits.delete();
  exp_frames = '0;
  exp_ovf    = 1'b0;
  exp_par    = 1'b0;
  exp_tok    = 1'b0;
  exp_crc    = 1'b0;
  exp_pre    = 1'b0;
  rx_on      = 1'b0;
  crc_acc    = CRC5_INIT;
endtask

task automatic push_bits(input logic [31:0] v, input int n);
  for (int i = n - 1; i >= 0; i--)
    frame_bits.push_back(v[i]);
endtask

task automatic add_data_word(input logic [DATA_W-1:0] d, input logic [PAR_W-1:0] flip);
  rx_entry_t e;
  e.data       = d;
  e.parity_err = (flip != 2'b00);
  push_bits(2'b10, 2);
  push_bits(d, DATA_W);
  push_bits(word_parity(d) ^ flip, PAR_W);
  for (int i = DATA_W - 1; i >= 0; i--)
    crc_acc = crc5_next(crc_acc, d[i]);
  if (rx_on)
  begin
    // a full FIFO drops the word but the parity event still counts
    if (exp_q.size() < RX_FIFO_DEPTH)
      exp_q.push_back(e);
    else
      exp_ovf = 1'b1;
    if (e.parity_err)
      exp_par = 1'b1;
  end
endtask

task automatic add_crc_word(input logic [TOKEN_W-1:0] tok_flip, input logic [CRC_W-1:0] crc_flip);
  push_bits(2'b01, 2);
  push_bits(RX_TOKEN ^ tok_flip, TOKEN_W);
  push_bits(crc_acc ^ crc_flip, CRC_W);
  if (rx_on)
  begin
    exp_frames = exp_frames + 1'b1;
    if (tok_flip != '0)
      exp_tok = 1'b1;
    if (crc_flip != '0)
      exp_crc = 1'b1;
  end
  crc_acc = CRC5_INIT;
endtask

task automatic add_bad_preamble(input bit b);
  push_bits({b, b}, 2);
  if (rx_on)
    exp_pre = 1'b1;
  crc_acc = CRC5_INIT;
endtask

function automatic rx_status_t expected_status();
  rx_status_t s;
  s             = '0;
  s.frame_count = exp_frames;
  s.pre_err     = exp_pre;
  s.crc_err     = exp_crc;
  s.token_err   = exp_tok;
  s.parity_err  = exp_par;
  s.overflow    = exp_ovf;
  s.full        = (exp_q.size() == RX_FIFO_DEPTH);
  s.empty       = (exp_q.size() == 0);
  return s;
endfunction

task automatic check_entry(input string name, input rx_entry_t exp, input rx_entry_t act);
  if (act !== exp)
    fail_run($sformatf("Mismatch %s: expected data %h perr %b, actual data %h perr %b",
                       name, exp.data, exp.parity_err, act.data, act.parity_err));
endtask

task automatic check_status(input string name, input rx_status_t exp, input rx_status_t act);
  if (act !== exp)
    fail_run($sformatf("Mismatch %s: expected status %h, actual status %h", name, exp, act));
endtask

/* testbench/ddr_rx_tb.sv */
//*********************************************************************
// ddr_rx_tb
// testbench for the HDR-DDR receive path: drives SCL/SDA frames and
// APB accesses and checks them against a reference model
//*********************************************************************
`timescale 1ns/1ps

module ddr_rx_tb;
  import ddr_rx_pkg::*;

  localparam int CLK_PERIOD     = 20;
  localparam int HALF_CLKS      = 10;
  localparam int MAX_FRAME_BITS = 4 * 20 + 11;
  localparam int NUM_FRAMES     = 17;
  localparam int SEED           = 80697;

  logic              sys_clk;
  logic              sys_rst;
  logic              scl;
  logic              sda;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [APB_AW-1:0] paddr;
  logic [APB_DW-1:0] pwdata;
  logic [APB_DW-1:0] prdata;
  logic              pready;
  logic              pslverr;
  logic [APB_DW-1:0] rd_data;
  logic              rd_err;
  logic              wr_err;

  ddr_rx_top dut_i (
    .i_sys_clk (sys_clk),
    .i_sys_rst (sys_rst),
    .i_scl     (scl),
    .i_sda     (sda),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "ddr_rx_model.svh"

  initial
  begin
    sys_clk = 1'b0;
    forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // inputs change 2 ns after the rising edge
  task automatic wait_clocks(input int n);
    repeat (n) @(posedge sys_clk);
    #2;
  endtask

  task automatic wait_for_idle();
    wait_clocks(1);
    wait (dut_i.bus_idle === 1'b1);
    wait_clocks(2);
  endtask

  task automatic drive_frame();
    foreach (frame_bits[i])
    begin
      // SDA moves mid half period, SCL edge carries the bit
      sda = frame_bits[i];
      wait_clocks(HALF_CLKS / 2);
      scl = ~scl;
      wait_clocks(HALF_CLKS / 2);
    end
    frame_bits.delete();
    // park SCL high so the bus goes idle
    if (!scl)
    begin
      sda = 1'b1;
      wait_clocks(HALF_CLKS / 2);
      scl = 1'b1;
    end
    wait_for_idle();
  endtask

  // zero wait states on every access
  task automatic check_ready();
    if (pready !== 1'b1)
      fail_run("PREADY was low during an APB access phase");
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
    psel    = 1'b1;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    wait_clocks(1);
    penable = 1'b1;
    #5;
    check_ready();
    wr_err  = pslverr;
    wait_clocks(1);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                          output logic err);
    psel    = 1'b1;
    pwrite  = 1'b0;
    paddr   = addr;
    wait_clocks(1);
    penable = 1'b1;
    // mid access phase, registers settled
    #5;
    check_ready();
    data    = prdata;
    err     = pslverr;
    wait_clocks(1);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_data_check(input string name);
    rx_entry_t exp;
    exp = '0;
    if (exp_q.size() > 0)
      exp = exp_q.pop_front();
    apb_read(ADDR_DATA, rd_data, rd_err);
    check_entry(name, exp, rd_data[$bits(rx_entry_t)-1:0]);
  endtask

  task automatic drain(input string name);
    while (exp_q.size() > 0)
      read_data_check(name);
  endtask

  task automatic read_status_check(input string name);
    apb_read(ADDR_STATUS, rd_data, rd_err);
    if (rd_err)
      fail_run("a STATUS read raised PSLVERR");
    check_status(name, expected_status(), rd_data[$bits(rx_status_t)-1:0]);
  endtask

  task automatic send_random_frame(input int nwords, input bit corrupt,
                                   input logic [TOKEN_W-1:0] tok_flip,
                                   input logic [CRC_W-1:0] crc_flip);
    logic [PAR_W-1:0] flip;
    for (int i = 0; i < nwords; i++)
    begin
      flip = 2'b00;
      // first word always corrupted so the sticky bit is exercised
      if (corrupt && (i == 0 || $urandom_range(0, 1) == 1))
        flip = PAR_W'($urandom_range(1, 3));
      add_data_word(DATA_W'($urandom), flip);
    end
    add_crc_word(tok_flip, crc_flip);
    drive_frame();
  endtask

  // watchdog
  initial
  begin
    #(NUM_FRAMES * MAX_FRAME_BITS * 20 * HALF_CLKS * CLK_PERIOD + 100000);
    fail_run("timeout: the test sequence did not finish in time");
  end

  initial
  begin
    void'($urandom(SEED));
    sys_rst = 1'b0;
    scl     = 1'b1;
    sda     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    wr_err  = 1'b0;
    reset_model();
    wait_clocks(3);
    sys_rst = 1'b1;
    apb_write(ADDR_CTRL, 32'h1);
    rx_on = 1'b1;
    wait_for_idle();

    // clean frames
    for (int f = 0; f < 6; f++)
    begin
      send_random_frame($urandom_range(1, 4), 1'b0, '0, '0);
      drain("clean data");
    end
    read_status_check("clean status");

    // corrupted parity, then W1C
    for (int f = 0; f < 2; f++)
    begin
      send_random_frame($urandom_range(1, 4), 1'b1, '0, '0);
      drain("parity data");
    end
    read_status_check("parity status");
    apb_write(ADDR_STATUS, 32'h08);
    exp_par = 1'b0;
    read_status_check("parity clear");

    // bad CRC and bad token
    send_random_frame(2, 1'b0, '0, CRC_W'($urandom_range(1, 31)));
    drain("bad crc data");
    send_random_frame(2, 1'b0, TOKEN_W'($urandom_range(1, 15)), '0);
    drain("bad token data");
    read_status_check("crc token status");
    apb_write(ADDR_STATUS, 32'h30);
    exp_crc = 1'b0;
    exp_tok = 1'b0;
    read_status_check("crc token clear");

    // bad preamble abandons the frame, rest of it is noise
    add_data_word(DATA_W'($urandom), 2'b00);
    add_bad_preamble($urandom_range(0, 1));
    push_bits($urandom, 12);
    drive_frame();
    send_random_frame(3, 1'b0, '0, '0);
    drain("preamble recovery data");
    read_status_check("preamble status");
    apb_write(ADDR_STATUS, 32'h40);
    exp_pre = 1'b0;
    read_status_check("preamble clear");

    // overflow with no reads
    send_random_frame(4, 1'b0, '0, '0);
    send_random_frame(4, 1'b0, '0, '0);
    send_random_frame(2, 1'b0, '0, '0);
    read_status_check("overflow status");
    drain("overflow data");
    read_data_check("empty read");
    read_status_check("drained status");
    apb_write(ADDR_STATUS, 32'h04);
    exp_ovf = 1'b0;
    read_status_check("overflow clear");

    // receiver disabled, then unmapped accesses
    apb_write(ADDR_CTRL, 32'h0);
    rx_on = 1'b0;
    send_random_frame(3, 1'b0, '0, '0);
    read_status_check("disabled status");
    apb_read(8'h0C, rd_data, rd_err);
    if (!rd_err)
      fail_run("a read of an unmapped address did not raise PSLVERR");
    apb_write(8'h10, 32'hFFFF_FFFF);
    if (!wr_err)
      fail_run("a write to an unmapped address did not raise PSLVERR");
    // a stray write must leave the receiver off
    send_random_frame(1, 1'b0, '0, '0);
    read_status_check("unmapped write");

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* source/ddr_rx_top.sv */
//*********************************************************************
// ddr_rx_top
// HDR-DDR receive path from the SCL/SDA pins to the APB registers
//*********************************************************************
`timescale 1ns/1ps

module ddr_rx_top (
  input  logic                          i_sys_clk,
  input  logic                          i_sys_rst,
  input  logic                          i_scl,
  input  logic                          i_sda,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [ddr_rx_pkg::APB_AW-1:0] i_paddr,
  input  logic [ddr_rx_pkg::APB_DW-1:0] i_pwdata,
  output logic [ddr_rx_pkg::APB_DW-1:0] o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr
);
  import ddr_rx_pkg::*;

  rx_bit_t          rx_bit;
  logic             bus_idle;
  logic             data_bit_valid;
  logic             data_bit;
  rx_word_t         word;
  logic [CRC_W-1:0] crc;
  logic             crc_restart;
  logic             push;
  rx_entry_t        entry;
  rx_event_t        evt;
  rx_entry_t        head;
  logic             empty;
  logic             full;
  logic             overflow;
  logic             enable;
  logic             pop;

  ddr_scl_sampler u_sampler (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_scl      (i_scl),
    .i_sda      (i_sda),
    .o_bit      (rx_bit),
    .o_bus_idle (bus_idle)
  );

  ddr_word_deserializer u_deser (
    .i_sys_clk        (i_sys_clk),
    .i_sys_rst        (i_sys_rst),
    .i_enable         (enable),
    .i_bit            (rx_bit),
    .i_bus_idle       (bus_idle),
    .o_data_bit_valid (data_bit_valid),
    .o_data_bit       (data_bit),
    .o_word           (word)
  );

  // runs beside the deserializer on the payload bits
  ddr_crc5 u_crc5 (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_restart   (crc_restart),
    .i_bit_valid (data_bit_valid),
    .i_bit       (data_bit),
    .o_crc       (crc)
  );

  ddr_frame_checker u_checker (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_word        (word),
    .i_crc         (crc),
    .o_crc_restart (crc_restart),
    .o_push        (push),
    .o_entry       (entry),
    .o_event       (evt)
  );

  ddr_rx_fifo u_fifo (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_push     (push),
    .i_entry    (entry),
    .i_pop      (pop),
    .o_head     (head),
    .o_empty    (empty),
    .o_full     (full),
    .o_overflow (overflow)
  );

  ddr_rx_apb_regs u_regs (
    .i_sys_clk  (i_sys_clk),
    .i_sys_rst  (i_sys_rst),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .i_event    (evt),
    .i_head     (head),
    .i_empty    (empty),
    .i_full     (full),
    .i_overflow (overflow),
    .o_enable   (enable),
    .o_pop      (pop)
  );

endmodule

/* source/ddr_rx_apb_regs.sv */
//*********************************************************************
// ddr_rx_apb_regs
// APB3 slave with CTRL, STATUS and DATA registers, sticky error
// flags and the frame counter
//*********************************************************************
`timescale 1ns/1ps

module ddr_rx_apb_regs (
  input  logic                          i_sys_clk,
  input  logic                          i_sys_rst,
  input  logic                          i_psel,
  input  logic                          i_penable,
  input  logic                          i_pwrite,
  input  logic [ddr_rx_pkg::APB_AW-1:0] i_paddr,
  input  logic [ddr_rx_pkg::APB_DW-1:0] i_pwdata,
  output logic [ddr_rx_pkg::APB_DW-1:0] o_prdata,
  output logic                          o_pready,
  output logic                          o_pslverr,
  input  ddr_rx_pkg::rx_event_t         i_event,
  input  ddr_rx_pkg::rx_entry_t         i_head,
  input  logic                          i_empty,
  input  logic                          i_full,
  input  logic                          i_overflow,
  output logic                          o_enable,
  output logic                          o_pop
);
  import ddr_rx_pkg::*;

  logic                   access;
  logic                   mapped;
  logic                   wr_status;
  logic [FRAME_CNT_W-1:0] frame_cnt;
  logic                   ovf_flag;
  logic                   par_flag;
  logic                   tok_flag;
  logic                   crc_flag;
  logic                   pre_flag;
  rx_status_t             status;

  assign access    = i_psel && i_penable;
  assign mapped    = (i_paddr == ADDR_CTRL) || (i_paddr == ADDR_STATUS) ||
                     (i_paddr == ADDR_DATA);
  assign wr_status = access && i_pwrite && (i_paddr == ADDR_STATUS);
  // zero wait states
  assign o_pready  = 1'b1;
  assign o_pslverr = access && !mapped;
  assign o_pop     = access && !i_pwrite && (i_paddr == ADDR_DATA) && !i_empty;

  always_comb
  begin
    status             = '0;
    status.frame_count = frame_cnt;
    status.pre_err     = pre_flag;
    status.crc_err     = crc_flag;
    status.token_err   = tok_flag;
    status.parity_err  = par_flag;
    status.overflow    = ovf_flag;
    status.full        = i_full;
    status.empty       = i_empty;
  end

  always_comb
  begin
    o_prdata = '0;
    if (access && !i_pwrite)
    begin
      case (i_paddr)
        ADDR_CTRL:   o_prdata[0] = o_enable;
        ADDR_STATUS: o_prdata[$bits(rx_status_t)-1:0] = status;
        ADDR_DATA:   o_prdata[$bits(rx_entry_t)-1:0] = i_empty ? '0 : i_head;
        default:     o_prdata = '0;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      o_enable  <= 1'b0;
      frame_cnt <= '0;
      ovf_flag  <= 1'b0;
      par_flag  <= 1'b0;
      tok_flag  <= 1'b0;
      crc_flag  <= 1'b0;
      pre_flag  <= 1'b0;
    end
    else
    begin
      if (access && i_pwrite && (i_paddr == ADDR_CTRL))
        o_enable <= i_pwdata[0];
      if (i_event.frame_done)
        frame_cnt <= frame_cnt + 1'b1;
      // write-1-to-clear, a new event in the same cycle wins
      if (wr_status && i_pwdata[2])
        ovf_flag <= 1'b0;
      if (wr_status && i_pwdata[3])
        par_flag <= 1'b0;
      if (wr_status && i_pwdata[4])
        tok_flag <= 1'b0;
      if (wr_status && i_pwdata[5])
        crc_flag <= 1'b0;
      if (wr_status && i_pwdata[6])
        pre_flag <= 1'b0;
      if (i_overflow)
        ovf_flag <= 1'b1;
      if (i_event.parity_err)
        par_flag <= 1'b1;
      if (i_event.token_err)
        tok_flag <= 1'b1;
      if (i_event.crc_err)
        crc_flag <= 1'b1;
      if (i_event.pre_err)
        pre_flag <= 1'b1;
    end
  end

endmodule

/* source/ddr_rx_fifo.sv */
//*********************************************************************
// ddr_rx_fifo
// circular buffer of received words, drops and flags a push when full
//*********************************************************************
`timescale 1ns/1ps

module ddr_rx_fifo (
  input  logic                  i_sys_clk,
  input  logic                  i_sys_rst,
  input  logic                  i_push,
  input  ddr_rx_pkg::rx_entry_t i_entry,
  input  logic                  i_pop,
  output ddr_rx_pkg::rx_entry_t o_head,
  output logic                  o_empty,
  output logic                  o_full,
  output logic                  o_overflow
);
  import ddr_rx_pkg::*;

  rx_entry_t                mem [RX_FIFO_DEPTH];
  logic [RX_FIFO_PTR_W-1:0] wr_ptr;
  logic [RX_FIFO_PTR_W-1:0] rd_ptr;
  logic [RX_FIFO_PTR_W:0]   count;
  logic                     do_push;
  logic                     do_pop;

  assign o_empty = (count == '0);
  assign o_full  = (count == (RX_FIFO_PTR_W + 1)'(RX_FIFO_DEPTH));
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;
  assign o_head  = mem[rd_ptr];

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      o_overflow <= 1'b0;
    end
    else
    begin
      // pointers wrap naturally, depth is a power of two
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
      o_overflow <= i_push && o_full;
    end
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_entry;
  end

endmodule

/* source/ddr_frame_checker.sv */
//*********************************************************************
// ddr_frame_checker
// checks parity, token, CRC and preamble of finished fields, pushes
// data words to the FIFO and raises frame events
//*********************************************************************
`timescale 1ns/1ps

module ddr_frame_checker (
  input  logic                         i_sys_clk,
  input  logic                         i_sys_rst,
  input  ddr_rx_pkg::rx_word_t         i_word,
  input  logic [ddr_rx_pkg::CRC_W-1:0] i_crc,
  output logic                         o_crc_restart,
  output logic                         o_push,
  output ddr_rx_pkg::rx_entry_t        o_entry,
  output ddr_rx_pkg::rx_event_t        o_event
);
  import ddr_rx_pkg::*;

  logic [PAR_W-1:0] calc_par;
  logic             par_err;
  logic             is_data;
  logic             is_crc;
  logic             is_bad;

  // odd bits into parity[1], even bits inverted into parity[0]
  function automatic logic [PAR_W-1:0] data_parity(input logic [DATA_W-1:0] d);
    logic [PAR_W-1:0] p;
    p = '0;
    for (int i = 0; i < DATA_W / 2; i++)
    begin
      p[1] = p[1] ^ d[2*i+1];
      p[0] = p[0] ^ d[2*i];
    end
    p[0] = ~p[0];
    return p;
  endfunction

  assign calc_par = data_parity(i_word.payload);
  assign par_err  = (calc_par != i_word.parity);
  assign is_data  = i_word.valid && (i_word.kind == FIELD_DATA);
  assign is_crc   = i_word.valid && (i_word.kind == FIELD_CRC);
  assign is_bad   = i_word.valid && (i_word.kind == FIELD_BAD_PRE);

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      o_push        <= 1'b0;
      o_crc_restart <= 1'b0;
      o_event       <= '0;
    end
    else
    begin
      o_push             <= is_data;
      // a closed or broken frame starts the next CRC afresh
      o_crc_restart      <= is_crc || is_bad;
      o_event.frame_done <= is_crc;
      o_event.token_err  <= is_crc && (i_word.token != RX_TOKEN);
      o_event.crc_err    <= is_crc && (i_word.crc != i_crc);
      o_event.pre_err    <= is_bad;
      o_event.parity_err <= is_data && par_err;
    end
  end

  // entry payload, qualified by o_push
  always_ff @(posedge i_sys_clk)
  begin
    if (is_data)
    begin
      o_entry.data       <= i_word.payload;
      o_entry.parity_err <= par_err;
    end
  end

endmodule

/* source/ddr_crc5.sv */
//*********************************************************************
// ddr_crc5
// bit-serial CRC5 over the data bits of the current frame
//*********************************************************************
`timescale 1ns/1ps

module ddr_crc5 (
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  logic                        i_restart,
  input  logic                        i_bit_valid,
  input  logic                        i_bit,
  output logic [ddr_rx_pkg::CRC_W-1:0] o_crc
);
  import ddr_rx_pkg::*;

  logic feedback;

  // MSB first, top bit leaves the register
  assign feedback = o_crc[CRC_W-1] ^ i_bit;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      o_crc <= CRC5_INIT;
    end
    else if (i_restart)
    begin
      o_crc <= CRC5_INIT;
    end
    else if (i_bit_valid)
    begin
      o_crc <= {o_crc[CRC_W-2:0], 1'b0} ^ (feedback ? CRC5_POLY : '0);
    end
  end

endmodule

/* source/ddr_word_deserializer.sv */
//*********************************************************************
// ddr_word_deserializer
// frame and word FSM: splits the bit stream into preamble, data,
// parity, token and CRC fields and reports each finished field
//*********************************************************************
`timescale 1ns/1ps

module ddr_word_deserializer (
  input  logic                 i_sys_clk,
  input  logic                 i_sys_rst,
  input  logic                 i_enable,
  input  ddr_rx_pkg::rx_bit_t  i_bit,
  input  logic                 i_bus_idle,
  output logic                 o_data_bit_valid,
  output logic                 o_data_bit,
  output ddr_rx_pkg::rx_word_t o_word
);
  import ddr_rx_pkg::*;

  typedef enum logic [2:0] {
    ST_PRE,
    ST_DATA,
    ST_PAR,
    ST_TOKEN,
    ST_CRC,
    ST_RESYNC
  } state_e;

  state_e            state;
  logic [3:0]        bit_cnt;
  logic [DATA_W-1:0] shreg;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      state            <= ST_RESYNC;
      bit_cnt          <= '0;
      shreg            <= '0;
      o_data_bit_valid <= 1'b0;
      o_data_bit       <= 1'b0;
      o_word           <= '0;
    end
    else
    begin
      o_word.valid     <= 1'b0;
      o_data_bit_valid <= 1'b0;
      if (!i_enable)
      begin
        state   <= ST_RESYNC;
        bit_cnt <= '0;
      end
      else if (i_bus_idle && !i_bit.valid)
      begin
        // idle bus, next edge opens a preamble
        state   <= ST_PRE;
        bit_cnt <= '0;
      end
      else if (i_bit.valid)
      begin
        shreg   <= {shreg[DATA_W-2:0], i_bit.sda};
        bit_cnt <= bit_cnt + 1'b1;
        case (state)
          ST_PRE:
          begin
            if (bit_cnt == 4'd1)
            begin
              bit_cnt <= '0;
              case ({shreg[0], i_bit.sda})
                2'b10: state <= ST_DATA;
                2'b01: state <= ST_TOKEN;
                default:
                begin
                  state        <= ST_RESYNC;
                  o_word.valid <= 1'b1;
                  o_word.kind  <= FIELD_BAD_PRE;
                end
              endcase
            end
          end
          ST_DATA:
          begin
            // payload bits also feed the CRC engine
            o_data_bit_valid <= 1'b1;
            o_data_bit       <= i_bit.sda;
            if (bit_cnt == 4'(DATA_W - 1))
            begin
              bit_cnt        <= '0;
              o_word.payload <= {shreg[DATA_W-2:0], i_bit.sda};
              state          <= ST_PAR;
            end
          end
          ST_PAR:
          begin
            if (bit_cnt == 4'(PAR_W - 1))
            begin
              bit_cnt       <= '0;
              o_word.parity <= {shreg[PAR_W-2:0], i_bit.sda};
              o_word.kind   <= FIELD_DATA;
              o_word.valid  <= 1'b1;
              state         <= ST_PRE;
            end
          end
          ST_TOKEN:
          begin
            if (bit_cnt == 4'(TOKEN_W - 1))
            begin
              bit_cnt      <= '0;
              o_word.token <= {shreg[TOKEN_W-2:0], i_bit.sda};
              state        <= ST_CRC;
            end
          end
          ST_CRC:
          begin
            if (bit_cnt == 4'(CRC_W - 1))
            begin
              bit_cnt      <= '0;
              o_word.crc   <= {shreg[CRC_W-2:0], i_bit.sda};
              o_word.kind  <= FIELD_CRC;
              o_word.valid <= 1'b1;
              // frame is over, wait for idle
              state        <= ST_RESYNC;
            end
          end
          default:
            bit_cnt <= '0;
        endcase
      end
    end
  end

endmodule

/* source/ddr_scl_sampler.sv */
//*********************************************************************
// ddr_scl_sampler
// brings SCL and SDA into the system clock domain, strobes one bit
// per SCL transition and flags an idle bus
//*********************************************************************
`timescale 1ns/1ps

module ddr_scl_sampler (
  input  logic                i_sys_clk,
  input  logic                i_sys_rst,
  input  logic                i_scl,
  input  logic                i_sda,
  output ddr_rx_pkg::rx_bit_t o_bit,
  output logic                o_bus_idle
);
  import ddr_rx_pkg::*;

  logic [1:0]            scl_sync;
  logic [1:0]            sda_sync;
  logic                  scl_q;
  logic [IDLE_CNT_W-1:0] idle_cnt;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      // bus rests high
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_q    <= 1'b1;
      o_bit    <= '0;
      idle_cnt <= '0;
    end
    else
    begin
      scl_sync    <= {scl_sync[0], i_scl};
      sda_sync    <= {sda_sync[0], i_sda};
      scl_q       <= scl_sync[1];
      // both SCL edges carry a bit
      o_bit.valid <= scl_sync[1] ^ scl_q;
      o_bit.sda   <= sda_sync[1];
      if (!scl_sync[1])
        idle_cnt <= '0;
      else if (!o_bus_idle)
        idle_cnt <= idle_cnt + 1'b1;
    end
  end

  // saturates once SCL has been high long enough
  assign o_bus_idle = (idle_cnt == IDLE_CNT_W'(IDLE_CYCLES));

endmodule

/* source/ddr_rx_pkg.sv */
//*********************************************************************
// ddr_rx_pkg
// protocol constants, register map and shared packed types for the
// I3C HDR-DDR receive path
//*********************************************************************
package ddr_rx_pkg;

  // field widths of an HDR-DDR word
  localparam int DATA_W  = 16;
  localparam int PAR_W   = 2;
  localparam int TOKEN_W = 4;
  localparam int CRC_W   = 5;

  localparam logic [TOKEN_W-1:0] RX_TOKEN  = 4'hC;
  localparam logic [CRC_W-1:0]   CRC5_INIT = 5'h1F;
  // x^5 + x^2 + 1, x^5 term implied
  localparam logic [CRC_W-1:0]   CRC5_POLY = 5'b00101;

  localparam int IDLE_CYCLES   = 16;
  localparam int IDLE_CNT_W    = $clog2(IDLE_CYCLES + 1);
  localparam int RX_FIFO_DEPTH = 8;
  localparam int RX_FIFO_PTR_W = $clog2(RX_FIFO_DEPTH);
  localparam int FRAME_CNT_W   = 8;

  // APB3 bus and register map
  localparam int APB_AW = 8;
  localparam int APB_DW = 32;
  localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;
  localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h04;
  localparam logic [APB_AW-1:0] ADDR_DATA   = 8'h08;

  typedef struct packed {
    logic valid;
    logic sda;
  } rx_bit_t;

  typedef enum logic [1:0] {
    FIELD_DATA    = 2'd0,
    FIELD_CRC     = 2'd1,
    FIELD_BAD_PRE = 2'd2
  } rx_field_e;

  typedef struct packed {
    logic               valid;
    rx_field_e          kind;
    logic [DATA_W-1:0]  payload;
    logic [PAR_W-1:0]   parity;
    logic [TOKEN_W-1:0] token;
    logic [CRC_W-1:0]   crc;
  } rx_word_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              parity_err;
  } rx_entry_t;

  typedef struct packed {
    logic frame_done;
    logic token_err;
    logic crc_err;
    logic pre_err;
    logic parity_err;
  } rx_event_t;

  typedef struct packed {
    logic [FRAME_CNT_W-1:0] frame_count;
    logic                   rsvd;
    logic                   pre_err;
    logic                   crc_err;
    logic                   token_err;
    logic                   parity_err;
    logic                   overflow;
    logic                   full;
    logic                   empty;
  } rx_status_t;

endpackage
